/* Makefile */
VERILATOR ?= verilator
TOP ?= tgen_tb
FLIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Test failed
PASS_MSG ?= Test passed
LINT_FLAGS ?= --lint-only --timing -Wall
BUILD_FLAGS ?= --binary --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/tgen_pkg.sv */
package tgen_pkg;

	// Local bus geometry
	localparam int lb_aw = 17;
	localparam int lb_dw = 32;

	// Program table holds 2**pcw words per bank
	// Four words make one entry, so 256 entries per bank
	localparam int pcw = 10;

	// Width of one program word
	localparam int word_w = 16;

	// Delay scaling as a left shift of the delay word
	localparam int tgen_gran = 0;

	// The timer must hold a full delay word after the shift
	localparam int tmr_w = word_w + tgen_gran;

	// Program table window starts at address bit 16
	localparam logic [lb_aw-1:0] dests_base = 17'h1_0000;

	// Register bank size and its address width
	localparam int reg_words = 64;
	localparam int reg_aw = $clog2(reg_words);

	// One write on the local bus
	// Single cycle strobe with no handshake
	typedef struct packed {
		logic we;
		logic [lb_aw-1:0] addr;
		logic [lb_dw-1:0] data;
	} lb_write_t;

	// Position of a word inside a four word program entry
	typedef enum logic [1:0] {
		ph_delay = 2'd0,
		ph_addr = 2'd1,
		ph_lo = 2'd2,
		ph_hi = 2'd3
	} tgen_phase_e;

endpackage

/* dv/tgen_tb.sv */
module tgen_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import tgen_pkg::*;

	localparam int n_prog = 3;
	localparam int max_ent = 6;
	localparam int max_delay = 7;
	// Idle time that proves a run has ended
	localparam int quiet_cycles = 4 + max_delay + 8;

	logic clk;
	logic rst_n;
	logic trig;
	lb_write_t host_bus;
	logic bank_next;
	logic [reg_aw-1:0] rd_addr;
	logic [lb_dw-1:0] rd_data;
	lb_write_t ctl_bus;
	logic [3:0] status;
	logic [15:0] collision_count;

	// Stimulus table, one row per program entry
	int prog_n [n_prog];
	logic [15:0] prog_delay [n_prog][max_ent];
	logic [15:0] prog_addr [n_prog][max_ent];
	logic [31:0] prog_data [n_prog][max_ent];

	// Reference model state
	logic [31:0] exp_regs [reg_words];
	logic tb_bank;
	logic last_work;
	logic [15:0] exp_coll;

	logic [31:0] lfsr;
	int unsigned cycle_count = 0;
	int unsigned timeout_limit = 0;
	logic table_ready = 1'b0;
	int err_count;
	int test_err0;
	int tests_pass;
	int tests_fail;

	// Writes seen on ctl_bus
	int unsigned obs_cycle [$];
	logic [lb_aw-1:0] obs_addr [$];
	logic [lb_dw-1:0] obs_data [$];
	// Host writes expected on ctl_bus during collisions
	logic [lb_aw-1:0] host_addr_q [$];
	logic [lb_dw-1:0] host_data_q [$];

	tgen_top u_tgen_top (
		.clk(clk),
		.rst_n(rst_n),
		.trig(trig),
		.host_bus(host_bus),
		.bank_next(bank_next),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.ctl_bus(ctl_bus),
		.status(status),
		.collision_count(collision_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Bus monitor at mid cycle
	always @(negedge clk) begin
		if (rst_n && ctl_bus.we) begin
			obs_cycle.push_back(cycle_count);
			obs_addr.push_back(ctl_bus.addr);
			obs_data.push_back(ctl_bus.data);
		end
	end

	initial begin : watchdog
		wait (table_ready);
		while (cycle_count < timeout_limit) begin
			@(posedge clk);
		end
		$display("Timeout, the run was still busy after %0d cycles", cycle_count);
		$display("Test failed");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic build_table();
		logic [31:0] v;
		prog_n = '{4, 6, 3};
		prog_addr[0] = '{16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0000, 16'h0000};
		// Address 0x02 again to check overwrite order
		prog_addr[1] = '{16'h0010, 16'h0011, 16'h0012, 16'h0002, 16'h003f, 16'h0005};
		prog_addr[2] = '{16'h0020, 16'h0021, 16'h0022, 16'h0000, 16'h0000, 16'h0000};
		for (int p = 0; p < n_prog; p++) begin
			for (int k = 0; k < max_ent; k++) begin
				take_bits(3, v);
				prog_delay[p][k] = v[15:0];
				take_bits(32, v);
				prog_data[p][k] = v;
			end
		end
		// Each program runs at most three times, table load included
		timeout_limit = 600;
		for (int p = 0; p < n_prog; p++) begin
			timeout_limit += 3 * ((prog_n[p] + 1) * (4 + max_delay + 4) + quiet_cycles);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[ERROR] %s got %h expected %h", name, got, exp);
		err_count++;
	endtask

	task automatic end_test(input string name);
		if (err_count == test_err0) begin
			tests_pass++;
			$display("%s: ok", name);
		end else begin
			tests_fail++;
			$display("%s: %0d errors", name, err_count - test_err0);
		end
		test_err0 = err_count;
	endtask

	task automatic host_write(input logic [lb_aw-1:0] a, input logic [lb_dw-1:0] d);
		host_bus = '{we: 1'b1, addr: a, data: d};
		next_cycle();
		host_bus.we = 1'b0;
	endtask

	// Fills the bank the sequencer is not playing
	task automatic load_program(input int p);
		logic [lb_aw-1:0] base;
		for (int k = 0; k <= prog_n[p]; k++) begin
			base = dests_base + lb_aw'(4 * k);
			if (k < prog_n[p]) begin
				// Upper halves are junk that the table drops
				host_write(base, {16'hbeef, prog_delay[p][k]});
				host_write(base + lb_aw'(1), {16'hbeef, prog_addr[p][k]});
				host_write(base + lb_aw'(2), {16'hbeef, prog_data[p][k][15:0]});
				host_write(base + lb_aw'(3), {16'hbeef, prog_data[p][k][31:16]});
			end else begin
				// Zero address word ends the program
				host_write(base, '0);
				host_write(base + lb_aw'(1), '0);
				host_write(base + lb_aw'(2), '0);
				host_write(base + lb_aw'(3), '0);
			end
		end
	endtask

	task automatic start_run(input int p, input logic flip);
		logic [3:0] exp_status;
		obs_cycle.delete();
		obs_addr.delete();
		obs_data.delete();
		bank_next = flip ? ~tb_bank : tb_bank;
		trig = 1'b1;
		next_cycle();
		trig = 1'b0;
		// Work bit, old bank, new bank, bank_next
		exp_status = {last_work, tb_bank, bank_next, bank_next};
		tb_bank = bank_next;
		last_work = (prog_n[p] > 0);
		@(negedge clk);
		if (status !== exp_status) begin
			report_value("status", 32'(status), 32'(exp_status));
		end
		next_cycle();
	endtask

	task automatic finish_run(input int p);
		int n;
		int gap;
		n = prog_n[p];
		while (obs_addr.size() < n) begin
			next_cycle();
		end
		repeat (quiet_cycles) next_cycle();
		if (obs_addr.size() != n) begin
			$display("Program %0d put %0d sequencer writes on ctl_bus where %0d were expected",
				p, obs_addr.size(), n);
			err_count++;
		end
		for (int k = 0; k < n && k < obs_addr.size(); k++) begin
			if (obs_addr[k] !== lb_aw'(prog_addr[p][k])) begin
				report_value("ctl_bus.addr", 32'(obs_addr[k]), 32'(prog_addr[p][k]));
			end
			if (obs_data[k] !== prog_data[p][k]) begin
				report_value("ctl_bus.data", obs_data[k], prog_data[p][k]);
			end
			// Spacing comes from the delay of the entry before
			if (k > 0) begin
				gap = 4 + (int'(prog_delay[p][k-1]) << tgen_gran);
				if (int'(obs_cycle[k] - obs_cycle[k-1]) != gap) begin
					report_value("ctl_bus write spacing", obs_cycle[k] - obs_cycle[k-1], gap);
				end
			end
		end
		// Register bank model follows the program table
		for (int k = 0; k < n; k++) begin
			if (prog_addr[p][k] < reg_words) begin
				exp_regs[prog_addr[p][k][reg_aw-1:0]] = prog_data[p][k];
			end
		end
		// No host traffic during playback, so no collisions
		if (collision_count !== exp_coll) begin
			report_value("collision_count", 32'(collision_count), 32'(exp_coll));
		end
	endtask

	task automatic check_regs();
		for (int i = 0; i < reg_words; i++) begin
			rd_addr = reg_aw'(i);
			@(negedge clk);
			if (rd_data !== exp_regs[i]) begin
				report_value($sformatf("rd_data[%0d]", i), rd_data, exp_regs[i]);
			end
			next_cycle();
		end
	endtask

	task automatic pass_through_test();
		logic [lb_aw-1:0] pt_addr [4];
		logic [31:0] d;
		pt_addr = '{17'h00005, 17'h0003f, 17'h00a00, 17'h0fffe};
		for (int i = 0; i < 4; i++) begin
			take_bits(32, d);
			host_write(pt_addr[i], d);
			rd_addr = pt_addr[i][reg_aw-1:0];
			// Merge register holds the write now
			@(negedge clk);
			if (ctl_bus.we !== 1'b1) begin
				report_value("ctl_bus.we", 32'(ctl_bus.we), 32'h1);
			end
			if (ctl_bus.addr !== pt_addr[i]) begin
				report_value("ctl_bus.addr", 32'(ctl_bus.addr), 32'(pt_addr[i]));
			end
			if (ctl_bus.data !== d) begin
				report_value("ctl_bus.data", ctl_bus.data, d);
			end
			next_cycle();
			// Out of range addresses leave the bank alone
			if (pt_addr[i] < reg_words) begin
				exp_regs[pt_addr[i][reg_aw-1:0]] = d;
			end
			@(negedge clk);
			if (rd_data !== exp_regs[pt_addr[i][reg_aw-1:0]]) begin
				report_value("rd_data", rd_data, exp_regs[pt_addr[i][reg_aw-1:0]]);
			end
			next_cycle();
		end
	endtask

	// Host strobes every cycle so each sequencer write loses
	task automatic collision_run(input int p);
		int n_cycles;
		logic [lb_aw-1:0] a;
		logic [31:0] d;
		logic [3:0] exp_status;
		n_cycles = 8 + prog_n[p] * (4 + max_delay);
		obs_cycle.delete();
		obs_addr.delete();
		obs_data.delete();
		host_addr_q.delete();
		host_data_q.delete();
		bank_next = ~tb_bank;
		exp_status = {last_work, tb_bank, bank_next, bank_next};
		for (int c = 0; c < n_cycles; c++) begin
			take_bits(32, d);
			a = 17'h00800 + lb_aw'(c & 255);
			host_bus = '{we: 1'b1, addr: a, data: d};
			trig = (c == 0);
			host_addr_q.push_back(a);
			host_data_q.push_back(d);
			next_cycle();
		end
		host_bus.we = 1'b0;
		trig = 1'b0;
		tb_bank = bank_next;
		last_work = (prog_n[p] > 0);
		// Every entry of the program loses to a host write
		exp_coll = exp_coll + 16'(prog_n[p]);
		repeat (quiet_cycles) next_cycle();
		if (obs_addr.size() != host_addr_q.size()) begin
			$display("ctl_bus carried %0d writes where %0d host writes were expected",
				obs_addr.size(), host_addr_q.size());
			err_count++;
		end
		for (int k = 0; k < obs_addr.size() && k < host_addr_q.size(); k++) begin
			if (obs_addr[k] !== host_addr_q[k]) begin
				report_value("ctl_bus.addr", 32'(obs_addr[k]), 32'(host_addr_q[k]));
			end
			if (obs_data[k] !== host_data_q[k]) begin
				report_value("ctl_bus.data", obs_data[k], host_data_q[k]);
			end
		end
		if (collision_count !== exp_coll) begin
			report_value("collision_count", 32'(collision_count), 32'(exp_coll));
		end
		if (status !== exp_status) begin
			report_value("status", 32'(status), 32'(exp_status));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		trig = 1'b0;
		host_bus = '0;
		bank_next = 1'b0;
		rd_addr = '0;
		lfsr = 32'h4e57;
		tb_bank = 1'b0;
		last_work = 1'b0;
		exp_coll = '0;
		err_count = 0;
		test_err0 = 0;
		tests_pass = 0;
		tests_fail = 0;
		for (int i = 0; i < reg_words; i++) begin
			exp_regs[i] = '0;
		end
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();

		pass_through_test();
		end_test("test 1 pass_through");

		// Program 1 lands in the idle bank while program 0 plays
		load_program(0);
		start_run(0, 1'b1);
		load_program(1);
		finish_run(0);
		end_test("test 2 bank_isolation");

		start_run(1, 1'b1);
		finish_run(1);
		check_regs();
		end_test("test 3 playback");

		// Same bank again, so the same program replays
		start_run(1, 1'b0);
		finish_run(1);
		check_regs();
		end_test("test 4 end_restart");

		load_program(2);
		collision_run(2);
		check_regs();
		end_test("test 5 collisions");

		$display("Tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, err_count);
		if (tests_fail == 0 && err_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* source/dpram.sv */
module dpram #(
	parameter int dw = 16,
	parameter int aw = 11
) (
	input logic clk,
	input logic [aw-1:0] wa,
	input logic [dw-1:0] wd,
	input logic we,
	input logic [aw-1:0] ra,
	output logic [dw-1:0] rd
);

	// Storage for both banks
	// Bank select is the top address bit
	logic [dw-1:0] mem [2**aw];

	// Write port A
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wa] <= wd;
		end
	end

	// Read port B with one cycle of latency
	always_ff @(posedge clk) begin
		rd <= mem[ra];
	end

endmodule

/* source/lb_decode.sv */
module lb_decode (
	input logic clk,
	input logic rst_n,
	input tgen_pkg::lb_write_t host_bus,
	input logic bank,
	output logic tbl_we,
	output logic [tgen_pkg::pcw:0] tbl_addr,
	output logic [tgen_pkg::word_w-1:0] tbl_data,
	output tgen_pkg::lb_write_t thru_bus
);
	import tgen_pkg::*;

	logic in_window;

	// Table window covers one bank of words above dests_base
	assign in_window = (host_bus.addr[lb_aw-1:pcw] == dests_base[lb_aw-1:pcw]);

	// Table writes
	assign tbl_we = host_bus.we && in_window;

	// Host fills the bank the sequencer is not reading
	assign tbl_addr = {bank, host_bus.addr[pcw-1:0]};

	// Program words are the low half of the bus data
	assign tbl_data = host_bus.data[word_w-1:0];

	// Everything else passes through to the merge
	assign thru_bus = '{
		we: host_bus.we && !in_window,
		addr: host_bus.addr,
		data: host_bus.data
	};

	// One host strobe goes to exactly one destination
	a_one_dest: assert property (@(posedge clk) disable iff (!rst_n)
		!(tbl_we && thru_bus.we))
		else $error("host write sent to table and pass-through");

endmodule

/* source/reg_bank.sv */
module reg_bank (
	input logic clk,
	input logic rst_n,
	input tgen_pkg::lb_write_t ctl_bus,
	input logic [tgen_pkg::reg_aw-1:0] rd_addr,
	output logic [tgen_pkg::lb_dw-1:0] rd_data
);
	import tgen_pkg::*;

	logic [lb_dw-1:0] regs [reg_words];
	logic hit;

	// Only addresses inside the bank range are taken
	assign hit = ctl_bus.we && (ctl_bus.addr[lb_aw-1:reg_aw] == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_words; i++) begin
				regs[i] <= '0;
			end
		end else if (hit) begin
			regs[ctl_bus.addr[reg_aw-1:0]] <= ctl_bus.data;
		end
	end

	// Combinational read
	assign rd_data = regs[rd_addr];

endmodule

/* source/tgen_top.sv */
module tgen_top (
	input logic clk,
	input logic rst_n,
	input logic trig,
	input tgen_pkg::lb_write_t host_bus,
	input logic bank_next,
	input logic [tgen_pkg::reg_aw-1:0] rd_addr,
	output logic [tgen_pkg::lb_dw-1:0] rd_data,
	output tgen_pkg::lb_write_t ctl_bus,
	output logic [3:0] status,
	output logic [15:0] collision_count
);
	import tgen_pkg::*;

	// Host side
	logic tbl_we;
	logic [pcw:0] tbl_addr;
	logic [word_w-1:0] tbl_data;
	lb_write_t thru_bus;

	// Sequencer side
	logic bank;
	logic [pcw:0] seq_ra;
	logic [word_w-1:0] seq_rd;
	lb_write_t seq_bus;

	lb_decode u_lb_decode (
		.clk(clk),
		.rst_n(rst_n),
		.host_bus(host_bus),
		.bank(bank),
		.tbl_we(tbl_we),
		.tbl_addr(tbl_addr),
		.tbl_data(tbl_data),
		.thru_bus(thru_bus)
	);

	// Both program banks in one RAM
	dpram #(.dw(word_w), .aw(pcw + 1)) u_dpram (
		.clk(clk),
		.wa(tbl_addr),
		.wd(tbl_data),
		.we(tbl_we),
		.ra(seq_ra),
		.rd(seq_rd)
	);

	tgen_seq u_tgen_seq (
		.clk(clk),
		.rst_n(rst_n),
		.trig(trig),
		.bank_next(bank_next),
		.rd_addr(seq_ra),
		.rd_word(seq_rd),
		.bank(bank),
		.seq_bus(seq_bus),
		.status(status)
	);

	tgen_merge u_tgen_merge (
		.clk(clk),
		.rst_n(rst_n),
		.thru_bus(thru_bus),
		.seq_bus(seq_bus),
		.ctl_bus(ctl_bus),
		.collision_count(collision_count)
	);

	reg_bank u_reg_bank (
		.clk(clk),
		.rst_n(rst_n),
		.ctl_bus(ctl_bus),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

/* tgen/tgen_merge.sv */
module tgen_merge (
	input logic clk,
	input logic rst_n,
	input tgen_pkg::lb_write_t thru_bus,
	input tgen_pkg::lb_write_t seq_bus,
	output tgen_pkg::lb_write_t ctl_bus,
	output logic [15:0] collision_count
);
	import tgen_pkg::*;

	logic ctl_we;
	logic [lb_aw-1:0] ctl_addr;
	logic [lb_dw-1:0] ctl_data;
	logic collide;

	// Both sources strobing in the same cycle
	assign collide = thru_bus.we && seq_bus.we;

	// Strobe and counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctl_we <= 1'b0;
			collision_count <= '0;
		end else begin
			ctl_we <= thru_bus.we || seq_bus.we;
			// Saturate instead of wrapping
			if (collide && (collision_count != '1)) begin
				collision_count <= collision_count + 1'b1;
			end
		end
	end

	// Host always wins the payload
	always_ff @(posedge clk) begin
		ctl_addr <= thru_bus.we ? thru_bus.addr : seq_bus.addr;
		ctl_data <= thru_bus.we ? thru_bus.data : seq_bus.data;
	end

	assign ctl_bus = '{we: ctl_we, addr: ctl_addr, data: ctl_data};

	// The lost write must leave the host write on the bus
	a_host_wins: assert property (@(posedge clk) disable iff (!rst_n)
		collide |=> (ctl_bus.we && (ctl_bus.addr == $past(thru_bus.addr))))
		else $error("collision without host write on ctl_bus");

endmodule

/* tgen/tgen_seq.sv */
module tgen_seq (
	input logic clk,
	input logic rst_n,
	input logic trig,
	input logic bank_next,
	output logic [tgen_pkg::pcw:0] rd_addr,
	input logic [tgen_pkg::word_w-1:0] rd_word,
	output logic bank,
	output tgen_pkg::lb_write_t seq_bus,
	output logic [3:0] status
);
	import tgen_pkg::*;

	logic [pcw-1:0] pc;
	logic [tmr_w-1:0] timer;
	tgen_phase_e phase;
	logic trig_ok;
	logic trig_d;
	logic advance;
	logic addr_zero;
	logic end_prog;
	logic write_cycle;
	logic did_work;
	logic bank_prev;
	logic work_prev;
	logic [word_w-1:0] word_d1;
	logic [word_w-1:0] word_d2;

	// Phase of the word being fetched
	// rd_word carries the word of the previous phase
	assign phase = tgen_phase_e'(pc[1:0]);

	// Trigger only counts while idle at pc zero
	assign trig_ok = trig && (pc == '0) && !trig_d;

	// Idle waits for the trigger
	// Delay phase holds until the timer runs out
	assign advance = (pc == '0) ? trig_d : ((phase != ph_delay) || (timer == '0));

	// Address word seen zero during ph_lo means end of program
	assign end_prog = (phase == ph_hi) && addr_zero;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			timer <= '0;
			trig_d <= 1'b0;
			addr_zero <= 1'b0;
			write_cycle <= 1'b0;
			did_work <= 1'b0;
		end else begin
			trig_d <= trig_ok;
			if (end_prog) begin
				pc <= '0;
			end else begin
				pc <= pc + pcw'(advance);
			end
			// Delay word arrives while pc points at the address word
			if (phase == ph_addr) begin
				timer <= tmr_w'(rd_word) << tgen_gran;
			end else if ((phase == ph_delay) && (timer != '0)) begin
				timer <= timer - 1'b1;
			end
			if (phase == ph_lo) begin
				addr_zero <= (rd_word == '0);
			end
			// Write goes out one cycle after the hi word is fetched
			write_cycle <= (phase == ph_hi) && !addr_zero;
			// Reaching the second entry means at least one write
			if (trig_ok) begin
				did_work <= 1'b0;
			end else if (pc[2]) begin
				did_work <= 1'b1;
			end
		end
	end

	// Bank flip is atomic with the trigger
	// bank_next may come from a slow or foreign domain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank <= 1'b0;
			bank_prev <= 1'b0;
			work_prev <= 1'b0;
		end else if (trig_ok) begin
			bank <= bank_next;
			bank_prev <= bank;
			work_prev <= did_work;
		end
	end

	// Word pipeline
	// Holds the address and lo words until hi arrives
	always_ff @(posedge clk) begin
		word_d1 <= rd_word;
		word_d2 <= word_d1;
	end

	// Playing bank is the inverse of the bank register
	assign rd_addr = {~bank, pc};

	assign seq_bus = '{we: write_cycle, addr: lb_aw'(word_d2), data: {rd_word, word_d1}};

	assign status = {work_prev, bank_prev, bank, bank_next};

	// A timer reload can only come from the delay word
	a_timer_load: assert property (@(posedge clk) disable iff (!rst_n)
		(timer > $past(timer)) |-> ($past(phase) == ph_addr))
		else $error("timer loaded outside ph_addr");

endmodule

/* vlog.f */
common/tgen_pkg.sv
source/dpram.sv
tgen/tgen_seq.sv
tgen/tgen_merge.sv
source/lb_decode.sv
source/reg_bank.sv
source/tgen_top.sv
dv/tgen_tb.sv
